/* flist.f */
rv_pkg.sv
rv_decode_if.sv
rv_regfile.sv
rv_decoder.sv
rv_alu.sv
rv_lsu.sv
rv_pc_unit.sv
rv_core.sv
rv_core_chk.sv
tb_rv_core.sv

/* run.sh */
#!/bin/sh
# Build the core testbench with Verilator, run it, and pass only on the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module tb_rv_core -f flist.f -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "^test passed$" &&
echo "PASS" && exit 0 ||
{ echo "FAIL"; exit 1; }

/* tb_rv_core.sv */
`default_nettype none

module tb_rv_core import rv_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          CLK_PERIOD   = 4;
  localparam int          RESET_CYCLES = 8;
  localparam int          NUM_INSNS    = 2000;
  localparam int          TIMEOUT_NS   = (NUM_INSNS + RESET_CYCLES) * CLK_PERIOD * 2;
  localparam logic [31:0] SEED         = 32'h5ab71f21;
  localparam word_t       DATA_BASE    = 32'h0001_2000; // Start of the 256-byte data window
  localparam word_t       ECALL        = 32'h0000_0073;

  logic       clk;
  logic       rst;
  word_t      insn_from_imem;
  word_t      load_data_from_dmem;
  word_t      pc_to_imem;
  word_t      addr_to_dmem;
  word_t      store_data_to_dmem;
  logic [3:0] store_we_to_dmem;
  logic       halt;

  logic [31:0] lfsr;
  word_t       regs [32];
  word_t       model_pc;
  word_t       mem_model [word_t];

  // Expected bus activity of the current instruction
  word_t      exp_addr;
  word_t      exp_data;
  logic [3:0] exp_we;
  logic       is_mem;
  // Architectural update, applied at the rising edge
  logic       wb_en;
  reg_idx_t   wb_rd;
  word_t      wb_val;
  word_t      next_pc;

  rv_core #(.RESET_PC(RESET_PC_DEFAULT)) rv_core_i (
    .clk                 (clk),
    .rst                 (rst),
    .pc_to_imem          (pc_to_imem),
    .insn_from_imem      (insn_from_imem),
    .addr_to_dmem        (addr_to_dmem),
    .load_data_from_dmem (load_data_from_dmem),
    .store_data_to_dmem  (store_data_to_dmem),
    .store_we_to_dmem    (store_we_to_dmem),
    .halt                (halt)
  );

  bind rv_core rv_core_chk chk_i (
    .clk  (clk),
    .rst  (rst),
    .pc   (pc_to_imem),
    .insn (insn_from_imem),
    .we   (store_we_to_dmem),
    .halt (halt)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the instruction stream did not complete within %0d ns", TIMEOUT_NS);
    $display("test failed");
    $fatal(1, "Run ended by the watchdog");
  end

  task automatic compare(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("test failed");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] draw(input int nbits);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return val;
  endfunction

  function automatic word_t sext(input word_t v, input int bits);
    return word_t'($signed(v << (32 - bits)) >>> (32 - bits));
  endfunction

  // Destination never x1, which holds the data base
  function automatic reg_idx_t pick_rd();
    reg_idx_t r;
    r = 5'(draw(5));
    return (r == 5'd1) ? 5'd0 : r;
  endfunction

  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic taken_ref(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  // Unwritten words read back a pattern of their own address
  function automatic word_t mem_read(input word_t addr);
    word_t wa;
    wa = {addr[31:2], 2'b00};
    if (mem_model.exists(wa)) return mem_model[wa];
    return wa ^ 32'hdeadbeef;
  endfunction

  function automatic word_t load_ref(input word_t w, input logic [1:0] offs,
                                     input logic [2:0] f3);
    word_t lane;
    lane = w >> (8 * offs);
    case (f3)
      3'b000:  return {{24{lane[7]}}, lane[7:0]};
      3'b001:  return {{16{lane[15]}}, lane[15:0]};
      3'b100:  return {24'b0, lane[7:0]};
      3'b101:  return {16'b0, lane[15:0]};
      default: return lane;
    endcase
  endfunction

  task automatic issue_fixed(input word_t insn, input logic en, input reg_idx_t rd,
                             input word_t val, input word_t npc);
    exp_we              = 4'b0000;
    is_mem              = 1'b0;
    wb_en               = en;
    wb_rd               = rd;
    wb_val              = val;
    next_pc             = npc;
    load_data_from_dmem = '0;
    insn_from_imem      = insn;
  endtask

  task automatic issue_random();
    logic [3:0] kind;
    logic [2:0] f3;
    logic       alt;
    logic [1:0] sz;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    word_t      imm;
    word_t      a;
    word_t      b;
    word_t      target;
    word_t      insn;
    kind    = 4'(draw(4));
    f3      = 3'(draw(3));
    alt     = 1'(draw(1));
    sz      = 2'(draw(2));
    rd      = pick_rd();
    rs1     = 5'(draw(5));
    rs2     = 5'(draw(5));
    a       = regs[rs1];
    b       = regs[rs2];
    if (sz == 2'd3) sz = 2'd2;
    exp_we  = 4'b0000;
    is_mem  = 1'b0;
    wb_en   = 1'b1;
    wb_rd   = rd;
    next_pc = model_pc + 32'd4;
    load_data_from_dmem = '0;
    case (kind)
      4'd0, 4'd1, 4'd2: begin
        alt    = alt && (f3 == 3'd0 || f3 == 3'd5); // Only sub and sra use bit 30
        insn   = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP_REG};
        wb_val = alu_ref(f3, alt, a, b);
      end
      4'd3, 4'd4, 4'd5: begin
        alt = alt && f3 == 3'd5;
        if (f3 == 3'd1 || f3 == 3'd5) imm = {21'b0, alt, 5'b0, 5'(draw(5))};
        else imm = sext(draw(12), 12);
        insn   = {imm[11:0], rs1, f3, rd, OP_IMM};
        wb_val = alu_ref(f3, alt, a, imm);
      end
      4'd6, 4'd7: begin
        imm    = {20'(draw(20)), 12'b0};
        insn   = {imm[31:12], rd, (kind == 4'd6) ? OP_LUI : OP_AUIPC};
        wb_val = (kind == 4'd6) ? imm : model_pc + imm;
      end
      4'd8, 4'd9: begin
        if (f3[2:1] == 2'b01) f3[2] = 1'b1; // Map unused codes onto bltu and bgeu
        imm   = sext(draw(5) << 2, 7);
        insn  = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
        wb_en = 1'b0;
        if (taken_ref(f3, a, b)) next_pc = model_pc + imm;
      end
      4'd10: begin
        imm = draw(5);
        if (imm == 32'd0) imm = 32'd1;     // Never a jump to itself
        imm     = sext(imm << 2, 7);
        insn    = {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
        wb_val  = model_pc + 32'd4;
        next_pc = model_pc + imm;
      end
      4'd11: begin
        imm    = draw(6) << 2;
        imm[0] = 1'(draw(1));              // Bit 0 is dropped by the target rule
        target = (regs[1] + imm) & ~32'd1;
        if (target == model_pc) begin
          imm    = imm + 32'd4;
          target = target + 32'd4;
        end
        insn    = {imm[11:0], 5'd1, 3'b000, rd, OP_JALR};
        wb_val  = model_pc + 32'd4;
        next_pc = target;
      end
      4'd12, 4'd13: begin
        f3  = {alt && sz != 2'd2, 1'b0, sz};
        imm = draw(8);
        if (sz != 2'd0) imm[0] = 1'b0;
        if (sz == 2'd2) imm[1] = 1'b0;
        insn     = {imm[11:0], 5'd1, f3, rd, OP_LOAD};
        is_mem   = 1'b1;
        exp_addr = regs[1] + imm;
        wb_val   = load_ref(mem_read(exp_addr), exp_addr[1:0], f3);
        load_data_from_dmem = mem_read(exp_addr);
      end
      default: begin
        imm = draw(8);
        if (sz != 2'd0) imm[0] = 1'b0;
        if (sz == 2'd2) imm[1] = 1'b0;
        insn     = {imm[11:5], rs2, 5'd1, 1'b0, sz, imm[4:0], OP_STORE};
        is_mem   = 1'b1;
        wb_en    = 1'b0;
        exp_addr = regs[1] + imm;
        case (sz)
          2'd0: begin
            exp_we   = 4'b0001 << exp_addr[1:0];
            exp_data = {4{b[7:0]}};
          end
          2'd1: begin
            exp_we   = exp_addr[1] ? 4'b1100 : 4'b0011;
            exp_data = {2{b[15:0]}};
          end
          default: begin
            exp_we   = 4'b1111;
            exp_data = b;
          end
        endcase
      end
    endcase
    insn_from_imem = insn;
  endtask

  task automatic check_bus(input logic halting);
    compare("PC", pc_to_imem, model_pc);
    compare("halt", 32'(halt), 32'(halting));
    compare("store enables", 32'(store_we_to_dmem), 32'(exp_we));
    if (is_mem) compare("data address", addr_to_dmem, exp_addr);
    if (exp_we != 4'b0000) compare("store data", store_data_to_dmem, exp_data);
  endtask

  // Model state update at the edge that ends the instruction
  task automatic retire();
    word_t w;
    if (exp_we != 4'b0000) begin
      w = mem_read(exp_addr);
      for (int i = 0; i < 4; i++) begin
        if (exp_we[i]) w[8*i +: 8] = exp_data[8*i +: 8];
      end
      mem_model[{exp_addr[31:2], 2'b00}] = w;
    end
    if (wb_en && wb_rd != 5'd0) regs[wb_rd] = wb_val;
    model_pc = next_pc;
  endtask

  initial begin
    lfsr                = SEED;
    rst                 = 1'b1;
    insn_from_imem      = ECALL;
    load_data_from_dmem = '0;
    model_pc            = RESET_PC_DEFAULT;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end

    // Ecall and a store in turn, both held quiet by reset
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk);
      #1;
      insn_from_imem = i[0] ? {7'b0, 5'd2, 5'd0, 3'b010, 5'd0, OP_STORE} : ECALL;
      @(negedge clk);
      compare("PC in reset", pc_to_imem, RESET_PC_DEFAULT);
      compare("store enables in reset", 32'(store_we_to_dmem), 32'd0);
      compare("halt in reset", 32'(halt), 32'd0);
    end

    for (int k = 0; k <= NUM_INSNS + 1; k++) begin
      @(posedge clk);
      if (k > 0) retire();
      #1;
      if (k == 0) begin
        rst = 1'b0;
        issue_fixed({DATA_BASE[31:12], 5'd1, OP_LUI}, 1'b1, 5'd1, DATA_BASE,
                    model_pc + 32'd4);
      end else if (k <= NUM_INSNS) begin
        issue_random();
      end else begin
        issue_fixed(ECALL, 1'b0, 5'd0, 32'd0, model_pc);
      end
      @(negedge clk);
      check_bus(k == NUM_INSNS + 1);
    end

    // PC holds across the ecall edge
    @(posedge clk);
    retire();
    @(negedge clk);
    compare("PC after ecall", pc_to_imem, model_pc);
    compare("halt after ecall", 32'(halt), 32'd1);

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* rv_core_chk.sv */
`default_nettype none

module rv_core_chk import rv_pkg::*; (
  input logic       clk,
  input logic       rst,
  input word_t      pc,
  input word_t      insn,
  input logic [3:0] we,
  input logic       halt
);

  timeunit 1ns;
  timeprecision 100ps;

  logic self_branch; // Branch with a zero offset
  logic we_legal;

  assign self_branch = insn[6:0] == OP_BRANCH && insn[31:25] == 7'd0 && insn[11:7] == 5'd0;

  // Enable pattern allowed for the access size in funct3
  always_comb begin
    case (insn[13:12])
      2'b00:   we_legal = $onehot(we);
      2'b01:   we_legal = we == 4'b0011 || we == 4'b1100;
      default: we_legal = we == 4'b1111;
    endcase
  end

  pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("PC %h is not word aligned", pc);

  we_quiet_in_reset: assert property (@(posedge clk) rst |-> we == 4'b0000)
    else $error("Store enables %b active during reset", we);

  we_pattern: assert property (@(posedge clk) we != 4'b0000 |-> we_legal)
    else $error("Store enables %b do not fit the access size", we);

  pc_moves: assert property (@(posedge clk) disable iff (rst)
    (!halt && !self_branch) |=> pc != $past(pc))
    else $error("PC stuck at %h", pc);

endmodule

`default_nettype wire

/* rv_core.sv */
`default_nettype none

module rv_core import rv_pkg::*; #(
  parameter word_t RESET_PC = RESET_PC_DEFAULT
) (
  input  logic       clk,
  input  logic       rst,
  output word_t      pc_to_imem,
  input  word_t      insn_from_imem,
  output word_t      addr_to_dmem,
  input  word_t      load_data_from_dmem,
  output word_t      store_data_to_dmem,
  output logic [3:0] store_we_to_dmem,
  output logic       halt
);

  reg_idx_t   rd;
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      alu_result;
  logic       branch_taken;
  word_t      load_value;
  logic [3:0] lsu_we;
  word_t      pc_plus4;
  word_t      wb_data;

  decode_if dec_if ();

  rv_decoder decoder_i (.insn(insn_from_imem), .dec(dec_if.dec), .rd(rd));

  rv_regfile regfile_i (
    .clk      (clk),
    .rst      (rst),
    .rf       (dec_if.rf),
    .rd       (rd),
    .we       (dec_if.ctrl.reg_write), // Clear for ecall, stores and branches
    .wdata    (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_alu alu_i (
    .exe          (dec_if.exe),
    .pc           (pc_to_imem),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .result       (alu_result),
    .branch_taken (branch_taken)
  );

  rv_lsu lsu_i (
    .exe        (dec_if.exe),
    .addr       (alu_result),
    .rs2_data   (rs2_data),
    .load_raw   (load_data_from_dmem),
    .store_data (store_data_to_dmem),
    .store_we   (lsu_we),
    .load_value (load_value)
  );

  rv_pc_unit #(.RESET_PC(RESET_PC)) pc_unit_i (
    .clk          (clk),
    .rst          (rst),
    .exe          (dec_if.exe),
    .branch_taken (branch_taken),
    .alu_result   (alu_result),
    .pc           (pc_to_imem),
    .pc_plus4     (pc_plus4)
  );

  // Write-back source
  always_comb begin
    case (dec_if.ctrl.wb_sel)
      WB_LOAD: wb_data = load_value;
      WB_PC4:  wb_data = pc_plus4;
      default: wb_data = alu_result;
    endcase
  end

  assign addr_to_dmem     = alu_result; // Byte address, memory picks the word
  assign store_we_to_dmem = rst ? 4'b0000 : lsu_we;
  assign halt             = dec_if.ctrl.is_ecall && !rst;

endmodule

`default_nettype wire

/* rv_pc_unit.sv */
`default_nettype none

module rv_pc_unit import rv_pkg::*; #(
  parameter word_t RESET_PC = RESET_PC_DEFAULT
) (
  input  logic  clk,
  input  logic  rst,
  decode_if.exe exe,
  input  logic  branch_taken,
  input  word_t alu_result,
  output word_t pc,
  output word_t pc_plus4
);

  word_t pc_next;

  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    if (exe.ctrl.is_ecall) begin
      pc_next = pc; // Halted, hold the PC
    end else if (exe.ctrl.is_jal || (exe.ctrl.is_branch && branch_taken)) begin
      pc_next = pc + exe.imm;
    end else if (exe.ctrl.is_jalr) begin
      pc_next = {alu_result[XLEN-1:1], 1'b0};
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) pc <= RESET_PC;
    else     pc <= pc_next;
  end

endmodule

`default_nettype wire

/* rv_lsu.sv */
`default_nettype none

module rv_lsu import rv_pkg::*; (
  decode_if.exe exe,
  input  word_t       addr,
  input  word_t       rs2_data,
  input  word_t       load_raw,
  output word_t       store_data,
  output logic [3:0]  store_we,
  output word_t       load_value
);

  logic [1:0] offs;
  logic [3:0] lane_we;
  word_t      shifted;
  word_t      extended;

  assign offs    = addr[1:0];
  assign shifted = load_raw >> {offs, 3'b000}; // Addressed lane down to bit 0

  // Replicate narrow data so every lane carries it
  always_comb begin
    case (exe.ctrl.mem_size)
      MEM_BYTE: begin
        store_data = {4{rs2_data[7:0]}};
        lane_we    = 4'b0001 << offs;
      end
      MEM_HALF: begin
        store_data = {2{rs2_data[15:0]}};
        lane_we    = offs[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        store_data = rs2_data;
        lane_we    = 4'b1111;
      end
    endcase
  end

  assign store_we = exe.ctrl.is_store ? lane_we : 4'b0000;

  always_comb begin
    case (exe.ctrl.mem_size)
      MEM_BYTE: extended = exe.ctrl.load_unsigned ? {24'b0, shifted[7:0]}
                                                  : {{24{shifted[7]}}, shifted[7:0]};
      MEM_HALF: extended = exe.ctrl.load_unsigned ? {16'b0, shifted[15:0]}
                                                  : {{16{shifted[15]}}, shifted[15:0]};
      default:  extended = shifted;
    endcase
  end

  assign load_value = extended;

endmodule

`default_nettype wire

/* rv_alu.sv */
`default_nettype none

module rv_alu import rv_pkg::*; (
  decode_if.exe exe,
  input  word_t pc,
  input  word_t rs1_data,
  input  word_t rs2_data,
  output word_t result,
  output logic  branch_taken
);

  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;
  logic       eq;
  logic       lt;
  logic       ltu;

  assign op_a  = (exe.ctrl.a_sel == A_PC) ? pc : rs1_data;
  assign op_b  = (exe.ctrl.b_sel == B_IMM) ? exe.imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (exe.ctrl.alu_op)
      ALU_ADD:   result = op_a + op_b;
      ALU_SUB:   result = op_a - op_b;
      ALU_SLL:   result = op_a << shamt;
      ALU_SLT:   result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:  result = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:   result = op_a ^ op_b;
      ALU_SRL:   result = op_a >> shamt;
      ALU_SRA:   result = word_t'($signed(op_a) >>> shamt);
      ALU_OR:    result = op_a | op_b;
      ALU_AND:   result = op_a & op_b;
      ALU_PASSB: result = op_b;
      default:   result = op_a + op_b;
    endcase
  end

  // Branch compare works on the registers, independent of the operand muxes
  assign eq  = rs1_data == rs2_data;
  assign lt  = $signed(rs1_data) < $signed(rs2_data);
  assign ltu = rs1_data < rs2_data;

  always_comb begin
    case (exe.ctrl.br_cond)
      BEQ:     branch_taken = eq;
      BNE:     branch_taken = !eq;
      BLT:     branch_taken = lt;
      BGE:     branch_taken = !lt;
      BLTU:    branch_taken = ltu;
      BGEU:    branch_taken = !ltu;
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* rv_decoder.sv */
`default_nettype none

module rv_decoder import rv_pkg::*; (
  input  word_t    insn,
  decode_if.dec    dec,
  output reg_idx_t rd
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic       alt;     // Bit 30, selects sub and sra
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  ctrl_t      ctrl;
  word_t      imm;

  assign opcode = opcode_t'(insn[6:0]);
  assign funct3 = insn[14:12];
  assign alt    = insn[30];

  assign rd      = insn[11:7];
  assign dec.rs1 = insn[19:15];
  assign dec.rs2 = insn[24:20];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

  // Shared by register and immediate arithmetic
  function automatic alu_op_t arith_op(input logic [2:0] f3, input logic sel);
    case (f3)
      3'b000:  arith_op = sel ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = sel ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  endfunction

  always_comb begin
    ctrl               = '0;
    ctrl.alu_op        = ALU_ADD;  // Address and auipc adds
    ctrl.a_sel         = A_RS1;
    ctrl.b_sel         = B_IMM;
    ctrl.wb_sel        = WB_ALU;
    ctrl.br_cond       = br_cond_t'(funct3);
    ctrl.mem_size      = mem_size_t'(funct3[1:0]);
    ctrl.load_unsigned = funct3[2];
    imm                = imm_i;

    case (opcode)
      OP_REG: begin
        ctrl.reg_write = 1'b1;
        ctrl.b_sel     = B_RS2;
        ctrl.alu_op    = arith_op(funct3, alt);
      end
      OP_IMM: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = arith_op(funct3, alt && funct3 == 3'b101); // addi never subtracts
      end
      OP_LUI: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = ALU_PASSB;
        imm            = imm_u;
      end
      OP_AUIPC: begin
        ctrl.reg_write = 1'b1;
        ctrl.a_sel     = A_PC;
        imm            = imm_u;
      end
      OP_JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.is_jal    = 1'b1;
        ctrl.wb_sel    = WB_PC4;
        imm            = imm_j;
      end
      OP_JALR: begin
        ctrl.reg_write = 1'b1;
        ctrl.is_jalr   = 1'b1;
        ctrl.wb_sel    = WB_PC4;
      end
      OP_BRANCH: begin
        ctrl.is_branch = 1'b1;
        imm            = imm_b;
      end
      OP_LOAD: begin
        ctrl.reg_write = 1'b1;
        ctrl.is_load   = 1'b1;
        ctrl.wb_sel    = WB_LOAD;
      end
      OP_STORE: begin
        ctrl.is_store = 1'b1;
        imm           = imm_s;
      end
      OP_SYSTEM: ctrl.is_ecall = 1'b1; // Only ecall is expected here
      default: ;
    endcase
  end

  assign dec.ctrl = ctrl;
  assign dec.imm  = imm;

endmodule

`default_nettype wire

/* rv_regfile.sv */
`default_nettype none

module rv_regfile import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  decode_if.rf     rf,
  input  reg_idx_t rd,
  input  logic     we,
  input  word_t    wdata,
  output word_t    rs1_data,
  output word_t    rs2_data
);

  word_t regs [1:31]; // x0 has no storage

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // Asynchronous reads, x0 reads as zero
  assign rs1_data = (rf.rs1 == '0) ? '0 : regs[rf.rs1];
  assign rs2_data = (rf.rs2 == '0) ? '0 : regs[rf.rs2];

endmodule

`default_nettype wire

/* rv_decode_if.sv */
`default_nettype none

// Decoded control from the decoder to the register file and execute side
interface decode_if import rv_pkg::*; ();

  ctrl_t    ctrl;
  word_t    imm;  // Sign-extended immediate
  reg_idx_t rs1;
  reg_idx_t rs2;

  modport dec (
    output ctrl, imm, rs1, rs2
  );

  modport exe (
    input ctrl, imm
  );

  modport rf (
    input rs1, rs2
  );

endinterface

`default_nettype wire

/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0] reg_idx_t;

  localparam word_t RESET_PC_DEFAULT = 32'h0000_0000;

  // Major opcodes, bits 6:0 of the instruction
  typedef enum logic [6:0] {
    OP_LOAD   = 7'b000_0011,
    OP_STORE  = 7'b010_0011,
    OP_BRANCH = 7'b110_0011,
    OP_JALR   = 7'b110_0111,
    OP_JAL    = 7'b110_1111,
    OP_IMM    = 7'b001_0011,
    OP_REG    = 7'b011_0011,
    OP_SYSTEM = 7'b111_0011,
    OP_AUIPC  = 7'b001_0111,
    OP_LUI    = 7'b011_0111
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD   = 4'd0,
    ALU_SUB   = 4'd1,
    ALU_SLL   = 4'd2,
    ALU_SLT   = 4'd3,
    ALU_SLTU  = 4'd4,
    ALU_XOR   = 4'd5,
    ALU_SRL   = 4'd6,
    ALU_SRA   = 4'd7,
    ALU_OR    = 4'd8,
    ALU_AND   = 4'd9,
    ALU_PASSB = 4'd10 // Operand b straight through, for lui
  } alu_op_t;

  // Branch funct3 codes
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } br_cond_t;

  // Same encoding as funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    MEM_BYTE = 2'b00,
    MEM_HALF = 2'b01,
    MEM_WORD = 2'b10
  } mem_size_t;

  typedef enum logic {A_RS1, A_PC} a_sel_t;
  typedef enum logic {B_RS2, B_IMM} b_sel_t;
  typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC4} wb_sel_t;

  typedef struct packed {
    alu_op_t   alu_op;
    a_sel_t    a_sel;
    b_sel_t    b_sel;
    logic      reg_write;
    wb_sel_t   wb_sel;
    logic      is_branch;
    br_cond_t  br_cond;
    logic      is_jal;
    logic      is_jalr;
    logic      is_load;
    logic      is_store;
    mem_size_t mem_size;
    logic      load_unsigned;
    logic      is_ecall;
  } ctrl_t;

endpackage

`default_nettype wire
